/* commitCore.f */
src/commitPkg.sv
src/reorderBuffer.sv
src/trapUnit.sv
src/commitRenameTable.sv
src/commitStage.sv
bench/commitStageTb.sv

/* build.sh */
#!/bin/sh
# compile the commit stage with its testbench under Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module commitStageTb \
    -Mdir obj_dir -o commitSim \
    -f commitCore.f
if [ $? -ne 0 ]; then
    echo "build.sh: compile failed"
    exit 1
fi

./obj_dir/commitSim
status=$?
if [ $status -ne 0 ]; then
    echo "build.sh: simulation exited with status $status"
    exit $status
fi
exit 0

/* bench/commitStim.txt */
# w flags tag name sqn pc isBranch taken branchID | s drives the pending w lines | i sqn | v vec
# c name tag sqn pc isBranch taken branchID | b dstPC sqn halt fence | t flags pc seg | l name tag | k n
v 00000800
w 0 22 02 01 00001004 0 0 00
w 0 23 03 02 00001008 0 0 00
s
w 0 21 01 00 00001000 0 0 00
s
w 0 25 05 05 00001014 0 0 00
w 0 00 00 04 00001010 1 1 05
w 0 24 04 03 0000100c 0 0 00
s
w 1 26 06 06 00001018 0 0 00
w 3 28 08 08 00001020 0 0 12
w 2 27 07 07 0000101c 0 1 34
s
w 4 29 09 09 00001024 0 0 00
s
w 0 31 0a 0b 0000102c 0 0 00
w 0 32 0b 0c 00001030 0 0 00
w 0 33 0c 0d 00001034 0 0 00
s
i 0b
w 0 30 0a 0a 00001028 0 0 00
w 0 42 0b 0c 00001030 0 0 00
w 0 43 0c 0d 00001034 0 0 00
s
c 01 21 00 00001000 0 0 00
c 02 22 01 00001004 0 0 00
c 03 23 02 00001008 0 0 00
c 04 24 03 0000100c 0 0 00
c 00 00 04 00001010 1 1 05
c 05 25 05 00001014 0 0 00
c 00 26 06 00001018 0 0 00
c 07 27 07 0000101c 0 1 34
c 00 28 08 00001020 0 0 12
c 09 29 09 00001024 0 0 00
c 0a 30 0a 00001028 0 0 00
c 0a 31 0b 0000102c 0 0 00
c 0b 42 0c 00001030 0 0 00
c 0c 43 0d 00001034 0 0 00
b 0000101c 06 1 0
b 00000800 07 0 0
b 00000800 08 0 0
b 00001028 09 0 1
t 2 0000101c 0f34
t 3 00001020 1012
l 0a 31
l 0b 42
l 0c 43
l 07 27
l 08 08
l 06 06
k 0000000e

/* bench/commitStageTb.sv */
`timescale 1ns/10ps

module commitStageTb;
    import commitPkg::*;

    // one parsed stimulus line
    typedef struct packed {
        logic [7:0] kind;
        ResUOp uop;
        logic [31:0] arg;
    } StimCmd;

    logic clk;
    logic rst;
    ResUOp wbUOp [WB_WIDTH-1:0];
    logic invalidate;
    SqN invalidateSqN;
    logic trapVecWrite;
    logic [31:0] trapVecData;
    logic [NAME_BITS-1:0] lookupName;
    CommitUOp comUOp [COMMIT_WIDTH-1:0];
    BranchProv branch;
    logic halt;
    logic fence;
    SqN maxSqN;
    SqN curSqN;
    TrapInfo trap;
    logic [TAG_BITS-1:0] lookupTag;
    logic [31:0] retiredCount;

    StimCmd stimCmds [$];
    ResUOp pending [$];
    CommitUOp expCommits [$];
    BranchProv expBranches [$];
    // halt in bit 1, fence in bit 0
    logic [1:0] expPulses [$];
    TrapInfo expTraps [$];
    logic [NAME_BITS-1:0] lookNames [$];
    logic [TAG_BITS-1:0] lookTags [$];
    logic [31:0] expCount;
    int stimLines;
    logic stimLoaded;

    // writeback group number per in-flight sqN, -1 when not in flight
    int wbStamp [2 ** SQN_BITS];
    logic wbPlain [2 ** SQN_BITS];
    logic wbBranch [2 ** SQN_BITS];
    int groupNo;

    commitStage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    // age by the signed difference of wrapping sequence numbers
    function automatic logic youngerThan(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return (a != b) && !diff[SQN_BITS-1];
    endfunction

    task automatic checkCommit(int lane, CommitUOp got, CommitUOp exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED %0t comUOp[%0d] got %h expected %h",
                $time, lane, got, exp));
        end
    endtask

    // valid lanes of one retire cycle against the wide-commit rule at its head
    task automatic checkLanes(logic [COMMIT_WIDTH-1:0] got, SqN headSq);
        SqN nextSq;
        SqN lastSq;
        logic canWide;
        logic mustWide;
        logic [COMMIT_WIDTH-1:0] exp;
        nextSq = headSq + SqN'(1);
        lastSq = headSq + SqN'(2);
        // all three written back, plain, and no branch behind the head
        canWide = wbStamp[headSq] >= 0 && wbStamp[nextSq] >= 0 && wbStamp[lastSq] >= 0
            && wbPlain[headSq] && wbPlain[nextSq] && wbPlain[lastSq]
            && !wbBranch[nextSq] && !wbBranch[lastSq];
        // the followers were already waiting when the head arrived
        mustWide = canWide && wbStamp[nextSq] <= wbStamp[headSq]
            && wbStamp[lastSq] <= wbStamp[headSq];
        if (mustWide || (canWide && got == '1)) begin
            exp = '1;
        end else begin
            exp = COMMIT_WIDTH'(1);
        end
        if (got !== exp) begin
            abortRun($sformatf("FAILED %0t comUOp valid lanes got %b expected %b",
                $time, got, exp));
        end
    endtask

    task automatic checkBranch(BranchProv got, logic gotHalt, logic gotFence,
                               BranchProv exp, logic expHalt, logic expFence);
        if (got !== exp) begin
            abortRun($sformatf("FAILED %0t branch got %h expected %h", $time, got, exp));
        end else if (gotHalt !== expHalt) begin
            abortRun($sformatf("FAILED %0t halt got %b expected %b", $time, gotHalt, expHalt));
        end else if (gotFence !== expFence) begin
            abortRun($sformatf("FAILED %0t fence got %b expected %b", $time, gotFence, expFence));
        end
    endtask

    task automatic checkTrap(TrapInfo got, TrapInfo exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED %0t trap got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic checkTag(logic [TAG_BITS-1:0] got, logic [TAG_BITS-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED %0t lookupTag got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic checkCount(logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED %0t retiredCount got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic checkSqN(string name, SqN got, SqN exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #10;
    endtask

    // splits the file into stimulus commands and expected records
    task automatic loadStimulus();
        int fd;
        logic [7:0] kind;
        string restText;
        logic [31:0] f [8];
        StimCmd cmd;
        fd = $fopen("bench/commitStim.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open the stimulus file bench/commitStim.txt");
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                void'($fgets(restText, fd));
                if (kind != "#") begin
                    for (int i = 0; i < 8; i++) begin
                        f[i] = '0;
                    end
                    void'($sscanf(restText, "%h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]));
                    stimLines++;
                    cmd = '0;
                    cmd.kind = kind;
                    cmd.arg = f[0];
                    case (kind)
                        "w": begin
                            cmd.uop = '{valid: 1'b1, flags: Flags'(f[0][2:0]),
                                tagDst: f[1][TAG_BITS-1:0], nmDst: f[2][NAME_BITS-1:0],
                                sqN: f[3][SQN_BITS-1:0], pc: f[4], isBranch: f[5][0],
                                branchTaken: f[6][0], branchID: f[7][7:0]};
                            stimCmds.push_back(cmd);
                        end
                        "s", "i", "v": stimCmds.push_back(cmd);
                        "c": expCommits.push_back('{valid: 1'b1,
                            nmDst: f[0][NAME_BITS-1:0], tagDst: f[1][TAG_BITS-1:0],
                            sqN: f[2][SQN_BITS-1:0], pc: f[3], isBranch: f[4][0],
                            branchTaken: f[5][0], branchID: f[6][7:0]});
                        "b": begin
                            expBranches.push_back('{taken: 1'b1, dstPC: f[0],
                                sqN: f[1][SQN_BITS-1:0], flush: 1'b1, storeSqN: '0,
                                loadSqN: '0});
                            expPulses.push_back({f[2][0], f[3][0]});
                        end
                        "t": expTraps.push_back('{valid: 1'b1, flags: Flags'(f[0][2:0]),
                            src: f[1], memAddr: f[2][14:0]});
                        "l": begin
                            lookNames.push_back(f[0][NAME_BITS-1:0]);
                            lookTags.push_back(f[1][TAG_BITS-1:0]);
                        end
                        "k": expCount = f[0];
                        default: abortRun($sformatf("unknown stimulus line starting with %s",
                            kind));
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // pending writebacks go out together, each on a random free port
    task automatic driveGroup();
        ResUOp ports [WB_WIDTH-1:0];
        int p;
        for (int i = 0; i < WB_WIDTH; i++) begin
            ports[i] = '0;
        end
        if (pending.size() > WB_WIDTH) begin
            abortRun("a stimulus group holds more writebacks than there are ports");
        end else begin
            foreach (pending[j]) begin
                p = int'($urandom % WB_WIDTH);
                while (ports[p].valid) begin
                    p = (p + 1) % WB_WIDTH;
                end
                ports[p] = pending[j];
                wbStamp[pending[j].sqN] = groupNo;
                wbPlain[pending[j].sqN] = pending[j].flags == FLAGS_NONE;
                wbBranch[pending[j].sqN] = pending[j].isBranch;
            end
            groupNo++;
            pending.delete();
            wbUOp = ports;
            nextCycle();
            for (int i = 0; i < WB_WIDTH; i++) begin
                wbUOp[i] = '0;
            end
        end
    endtask

    task automatic runCommand(StimCmd cmd);
        case (cmd.kind)
            "w": pending.push_back(cmd.uop);
            "s": driveGroup();
            "i": begin
                invalidate = 1'b1;
                invalidateSqN = cmd.arg[SQN_BITS-1:0];
                // dropped entries are no longer in flight
                for (int s = 0; s < 2 ** SQN_BITS; s++) begin
                    if (youngerThan(SqN'(s), invalidateSqN)) begin
                        wbStamp[s] = -1;
                    end
                end
                nextCycle();
                invalidate = 1'b0;
            end
            "v": begin
                trapVecWrite = 1'b1;
                trapVecData = cmd.arg;
                nextCycle();
                trapVecWrite = 1'b0;
            end
            default: ;
        endcase
    endtask

    // results are compared in arrival order, whatever cycle they land in
    always @(negedge clk) begin
        BranchProv nextBranch;
        logic [1:0] nextPulses;
        CommitUOp nextCommit;
        logic [COMMIT_WIDTH-1:0] validLanes;
        if (!rst) begin
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                validLanes[i] = comUOp[i].valid;
            end
            if (validLanes != '0 && expCommits.size() != 0) begin
                checkLanes(validLanes, expCommits[0].sqN);
            end
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (comUOp[i].valid) begin
                    if (expCommits.size() == 0) begin
                        abortRun($sformatf("unexpected commit on lane %0d with sqN %h",
                            i, comUOp[i].sqN));
                    end else begin
                        nextCommit = expCommits.pop_front();
                        checkCommit(i, comUOp[i], nextCommit);
                        wbStamp[nextCommit.sqN] = -1;
                    end
                end
            end
            if (branch.taken) begin
                if (expBranches.size() == 0) begin
                    abortRun("a redirect arrived with none expected");
                end else begin
                    nextBranch = expBranches.pop_front();
                    nextPulses = expPulses.pop_front();
                    checkBranch(branch, halt, fence, nextBranch, nextPulses[1], nextPulses[0]);
                end
            end else if (halt || fence) begin
                abortRun("halt or fence pulsed without a redirect");
            end
            if (trap.valid) begin
                if (expTraps.size() == 0) begin
                    abortRun("a trap record arrived with none expected");
                end else begin
                    checkTrap(trap, expTraps.pop_front());
                end
            end
        end
    end

    initial begin
        wait (stimLoaded);
        repeat (stimLines + 50) @(posedge clk);
        abortRun("timeout: expected results never arrived");
    end

    initial begin
        rst = 1'b1;
        invalidate = 1'b0;
        invalidateSqN = '0;
        trapVecWrite = 1'b0;
        trapVecData = '0;
        lookupName = '0;
        expCount = '0;
        stimLines = 0;
        stimLoaded = 1'b0;
        groupNo = 0;
        for (int i = 0; i < WB_WIDTH; i++) begin
            wbUOp[i] = '0;
        end
        for (int s = 0; s < 2 ** SQN_BITS; s++) begin
            wbStamp[s] = -1;
            wbPlain[s] = 1'b0;
            wbBranch[s] = 1'b0;
        end
        void'($urandom(25));
        loadStimulus();
        stimLoaded = 1'b1;

        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        // empty buffer out of reset
        checkSqN("curSqN", curSqN, '0);
        checkSqN("maxSqN", maxSqN, SqN'(ROB_LENGTH - 1));
        checkCount(retiredCount, '0);
        foreach (stimCmds[k]) begin
            runCommand(stimCmds[k]);
        end

        // wait until every expected record was seen, then let the map settle
        while (expCommits.size() != 0 || expBranches.size() != 0 || expTraps.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
        #10;
        foreach (lookNames[k]) begin
            lookupName = lookNames[k];
            @(negedge clk);
            checkTag(lookupTag, lookTags[k]);
            nextCycle();
        end
        checkCount(retiredCount, expCount);
        // the head moved once per retired op, the window spans the whole buffer
        checkSqN("curSqN", curSqN, SqN'(expCount));
        checkSqN("maxSqN", maxSqN, SqN'(expCount + ROB_LENGTH - 1));
        $display("All checks passed");
        $finish;
    end

endmodule

/* src/commitStage.sv */
`timescale 1ns/10ps

module commitStage (
    input  logic clk,
    input  logic rst,
    input  commitPkg::ResUOp wbUOp [commitPkg::WB_WIDTH-1:0],
    input  logic invalidate,
    input  commitPkg::SqN invalidateSqN,
    input  logic trapVecWrite,
    input  logic [31:0] trapVecData,
    input  logic [commitPkg::NAME_BITS-1:0] lookupName,
    output commitPkg::CommitUOp comUOp [commitPkg::COMMIT_WIDTH-1:0],
    output commitPkg::BranchProv branch,
    output logic halt,
    output logic fence,
    output commitPkg::SqN maxSqN,
    output commitPkg::SqN curSqN,
    output commitPkg::TrapInfo trap,
    output logic [commitPkg::TAG_BITS-1:0] lookupTag,
    output logic [31:0] retiredCount
);
    import commitPkg::*;

    TrapInfo trapOut;
    logic [31:0] trapVec;

    reorderBuffer i_rob (
        .clk(clk),
        .rst(rst),
        .wbUOp(wbUOp),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .trapVec(trapVec),
        .maxSqN(maxSqN),
        .curSqN(curSqN),
        .comUOp(comUOp),
        .branch(branch),
        .halt(halt),
        .fence(fence),
        .trapOut(trapOut)
    );

    trapUnit i_trap (
        .clk(clk),
        .rst(rst),
        .trapVecWrite(trapVecWrite),
        .trapVecData(trapVecData),
        .trapIn(trapOut),
        .trapVec(trapVec),
        .trap(trap)
    );

    // retired results update the architectural map
    commitRenameTable i_crt (
        .clk(clk),
        .rst(rst),
        .comUOp(comUOp),
        .lookupName(lookupName),
        .lookupTag(lookupTag),
        .retiredCount(retiredCount)
    );

endmodule

/* src/commitRenameTable.sv */
`timescale 1ns/10ps

module commitRenameTable (
    input  logic clk,
    input  logic rst,
    input  commitPkg::CommitUOp comUOp [commitPkg::COMMIT_WIDTH-1:0],
    input  logic [commitPkg::NAME_BITS-1:0] lookupName,
    output logic [commitPkg::TAG_BITS-1:0] lookupTag,
    output logic [31:0] retiredCount
);
    import commitPkg::*;

    localparam int NUM_NAMES = 2 ** NAME_BITS;

    // committed tag of each architectural register
    logic [TAG_BITS-1:0] nameMap [NUM_NAMES];
    logic [$clog2(COMMIT_WIDTH+1)-1:0] laneCount;

    always_comb begin
        laneCount = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (comUOp[i].valid) begin
                laneCount = laneCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity mapping out of reset
            for (int n = 0; n < NUM_NAMES; n++) begin
                nameMap[n] <= TAG_BITS'(n);
            end
        end else begin
            // later lanes are younger, so they overwrite earlier ones
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (comUOp[i].valid && comUOp[i].nmDst != '0) begin
                    nameMap[comUOp[i].nmDst] <= comUOp[i].tagDst;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retiredCount <= '0;
        end else begin
            retiredCount <= retiredCount + 32'(laneCount);
        end
    end

    assign lookupTag = nameMap[lookupName];

    // lanes retire in order, so lane 1 implies lane 0
    assert property (@(posedge clk) disable iff (rst)
        comUOp[1].valid |-> comUOp[0].valid);

endmodule

/* src/trapUnit.sv */
`timescale 1ns/10ps

module trapUnit (
    input  logic clk,
    input  logic rst,
    input  logic trapVecWrite,
    input  logic [31:0] trapVecData,
    input  commitPkg::TrapInfo trapIn,
    output logic [31:0] trapVec,
    output commitPkg::TrapInfo trap
);
    import commitPkg::*;

    logic [31:0] vecReg;
    logic trapPulse;
    Flags causeReg;
    logic [31:0] srcReg;
    logic [14:0] segReg;

    // handler address, software writes it before enabling traps
    always_ff @(posedge clk) begin
        if (rst) begin
            vecReg <= '0;
        end else if (trapVecWrite) begin
            vecReg <= trapVecData;
        end
    end

    assign trapVec = vecReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            trapPulse <= 1'b0;
        end else begin
            trapPulse <= trapIn.valid;
        end
    end

    // cause, pc and segment stay put until the next trap
    always_ff @(posedge clk) begin
        if (trapIn.valid) begin
            causeReg <= trapIn.flags;
            srcReg <= trapIn.src;
            segReg <= trapIn.memAddr;
        end
    end

    always_comb begin
        trap.valid = trapPulse;
        trap.flags = causeReg;
        trap.src = srcReg;
        trap.memAddr = segReg;
    end

    // only trap and exception heads produce a trap record
    assert property (@(posedge clk) disable iff (rst)
        trapIn.valid |-> (trapIn.flags == FLAGS_TRAP || trapIn.flags == FLAGS_EXCEPT));

endmodule

/* src/reorderBuffer.sv */
`timescale 1ns/10ps

module reorderBuffer (
    input  logic clk,
    input  logic rst,
    input  commitPkg::ResUOp wbUOp [commitPkg::WB_WIDTH-1:0],
    input  logic invalidate,
    input  commitPkg::SqN invalidateSqN,
    input  logic [31:0] trapVec,
    output commitPkg::SqN maxSqN,
    output commitPkg::SqN curSqN,
    output commitPkg::CommitUOp comUOp [commitPkg::COMMIT_WIDTH-1:0],
    output commitPkg::BranchProv branch,
    output logic halt,
    output logic fence,
    output commitPkg::TrapInfo trapOut
);
    import commitPkg::*;

    // payload of one slot, the valid bit lives in slotValid
    typedef struct packed {
        Flags flags;
        logic [TAG_BITS-1:0] tag;
        logic [NAME_BITS-1:0] name;
        SqN sqN;
        logic [31:0] pc;
        logic isBranch;
        logic branchTaken;
        logic [7:0] branchID;
    } RobEntry;

    RobEntry entries [ROB_LENGTH];
    logic [ROB_LENGTH-1:0] slotValid;
    SqN headSqN;

    logic [IDX_BITS-1:0] slotIdx [COMMIT_WIDTH];
    RobEntry head;
    logic wideCommit;
    logic singleCommit;
    logic [1:0] retireNum;
    logic [WB_WIDTH-1:0] wbAccept;

    CommitUOp comNext [COMMIT_WIDTH-1:0];
    BranchProv branchNext;
    TrapInfo trapNext;
    logic haltNext;
    logic fenceNext;

    // true when a is strictly younger than b
    function automatic logic isYounger(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    assign curSqN = headSqN;
    assign maxSqN = headSqN + SqN'(ROB_LENGTH - 1);

    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            slotIdx[i] = headSqN[IDX_BITS-1:0] + IDX_BITS'(i);
        end
        head = entries[slotIdx[0]];
    end

    // three-wide retire only for plain ops with no branch behind the head
    always_comb begin
        wideCommit = 1'b1;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (!slotValid[slotIdx[i]] || entries[slotIdx[i]].flags != FLAGS_NONE) begin
                wideCommit = 1'b0;
            end
        end
        if (entries[slotIdx[1]].isBranch || entries[slotIdx[2]].isBranch) begin
            wideCommit = 1'b0;
        end
        singleCommit = slotValid[slotIdx[0]];
        // a flush cycle retires nothing
        if (invalidate) begin
            wideCommit = 1'b0;
            singleCommit = 1'b0;
        end
    end

    always_comb begin
        retireNum = 2'd0;
        branchNext = '0;
        trapNext = '0;
        haltNext = 1'b0;
        fenceNext = 1'b0;

        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            comNext[i].valid = 1'b0;
            comNext[i].nmDst = entries[slotIdx[i]].name;
            comNext[i].tagDst = entries[slotIdx[i]].tag;
            comNext[i].sqN = headSqN + SqN'(i);
            comNext[i].pc = entries[slotIdx[i]].pc;
            comNext[i].isBranch = entries[slotIdx[i]].isBranch;
            comNext[i].branchTaken = entries[slotIdx[i]].branchTaken;
            comNext[i].branchID = entries[slotIdx[i]].branchID;
        end

        if (wideCommit) begin
            retireNum = 2'd3;
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                comNext[i].valid = 1'b1;
            end
        end else if (singleCommit) begin
            retireNum = 2'd1;
            comNext[0].valid = 1'b1;
            case (head.flags)
                FLAGS_BRK: begin
                    // resume after the ebreak so the debugger sees its effects
                    haltNext = 1'b1;
                    branchNext.taken = 1'b1;
                    branchNext.dstPC = head.pc + 32'd4;
                    branchNext.sqN = headSqN;
                    branchNext.flush = 1'b1;
                    comNext[0].nmDst = '0;
                end
                FLAGS_TRAP, FLAGS_EXCEPT: begin
                    branchNext.taken = 1'b1;
                    branchNext.dstPC = trapVec;
                    branchNext.sqN = headSqN;
                    branchNext.flush = 1'b1;
                    // an exception leaves no architectural result
                    if (head.flags == FLAGS_EXCEPT) begin
                        comNext[0].nmDst = '0;
                    end
                    trapNext.valid = 1'b1;
                    trapNext.flags = head.flags;
                    trapNext.src = head.pc;
                    // segment of the faulting address rides in name and branch fields
                    trapNext.memAddr = {head.name, head.branchTaken, head.branchID};
                end
                FLAGS_FENCE: begin
                    fenceNext = 1'b1;
                    branchNext.taken = 1'b1;
                    branchNext.dstPC = head.pc + 32'd4;
                    branchNext.sqN = headSqN;
                    branchNext.flush = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // writebacks younger than a concurrent invalidate are discarded
    always_comb begin
        for (int p = 0; p < WB_WIDTH; p++) begin
            wbAccept[p] = wbUOp[p].valid &&
                (!invalidate || !isYounger(wbUOp[p].sqN, invalidateSqN));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headSqN <= '0;
            slotValid <= '0;
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                comUOp[i].valid <= 1'b0;
            end
            branch.taken <= 1'b0;
            halt <= 1'b0;
            fence <= 1'b0;
            trapOut.valid <= 1'b0;
        end else begin
            headSqN <= headSqN + SqN'(retireNum);
            comUOp <= comNext;
            branch <= branchNext;
            halt <= haltNext;
            fence <= fenceNext;
            trapOut <= trapNext;

            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (i < retireNum) begin
                    slotValid[slotIdx[i]] <= 1'b0;
                end
            end
            if (invalidate) begin
                for (int s = 0; s < ROB_LENGTH; s++) begin
                    if (isYounger(entries[s].sqN, invalidateSqN)) begin
                        slotValid[s] <= 1'b0;
                    end
                end
            end
            // new results last so they win over a same-cycle clear
            for (int p = 0; p < WB_WIDTH; p++) begin
                if (wbAccept[p]) begin
                    slotValid[wbUOp[p].sqN[IDX_BITS-1:0]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < WB_WIDTH; p++) begin
            if (wbAccept[p]) begin
                entries[wbUOp[p].sqN[IDX_BITS-1:0]] <= '{
                    flags: wbUOp[p].flags,
                    tag: wbUOp[p].tagDst,
                    name: wbUOp[p].nmDst,
                    sqN: wbUOp[p].sqN,
                    pc: wbUOp[p].pc,
                    isBranch: wbUOp[p].isBranch,
                    branchTaken: wbUOp[p].branchTaken,
                    branchID: wbUOp[p].branchID
                };
            end
        end
    end

    // a slot is reused only after its previous occupant retired
    for (genvar p = 0; p < WB_WIDTH; p++) begin : gWbFree
        assert property (@(posedge clk) disable iff (rst)
            wbUOp[p].valid |-> !slotValid[wbUOp[p].sqN[IDX_BITS-1:0]]);
    end

    assert property (@(posedge clk) disable iff (rst) !(halt && fence));

    // every redirect belongs to the op retired with it
    assert property (@(posedge clk) disable iff (rst) branch.taken |-> comUOp[0].valid);

endmodule

/* src/commitPkg.sv */
package commitPkg;

    // buffer geometry
    localparam int ROB_LENGTH = 32;
    localparam int IDX_BITS = $clog2(ROB_LENGTH);
    localparam int COMMIT_WIDTH = 3;
    localparam int WB_WIDTH = 3;

    // sequence numbers carry one bit more than the slot index so age survives wrap
    localparam int SQN_BITS = 6;
    localparam int TAG_BITS = 7;
    localparam int NAME_BITS = 6;

    typedef logic [SQN_BITS-1:0] SqN;

    // special handling requested by a micro-op at retirement
    typedef enum logic [2:0] {
        FLAGS_NONE   = 3'd0,
        FLAGS_BRK    = 3'd1,
        FLAGS_TRAP   = 3'd2,
        FLAGS_EXCEPT = 3'd3,
        FLAGS_FENCE  = 3'd4
    } Flags;

    // writeback from an execution unit
    typedef struct packed {
        logic valid;
        Flags flags;
        logic [TAG_BITS-1:0] tagDst;
        logic [NAME_BITS-1:0] nmDst;
        SqN sqN;
        logic [31:0] pc;
        logic isBranch;
        logic branchTaken;
        logic [7:0] branchID;
    } ResUOp;

    // retired micro-op, one per commit lane
    typedef struct packed {
        logic valid;
        logic [NAME_BITS-1:0] nmDst;
        logic [TAG_BITS-1:0] tagDst;
        SqN sqN;
        logic [31:0] pc;
        logic isBranch;
        logic branchTaken;
        logic [7:0] branchID;
    } CommitUOp;

    // redirect request toward the front end
    typedef struct packed {
        logic taken;
        logic [31:0] dstPC;
        SqN sqN;
        logic flush;
        SqN storeSqN;
        SqN loadSqN;
    } BranchProv;

    // trap record, memAddr holds the faulting segment
    typedef struct packed {
        logic valid;
        Flags flags;
        logic [31:0] src;
        logic [14:0] memAddr;
    } TrapInfo;

endpackage
